//--- hdl/ifu_defs.svh
// Instruction fetch unit sizing macros
// Address and data widths, queue depth, transaction counter width

`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// --------------------
// Widths
// --------------------

`define IFU_XLEN        32  // PC and address width
`define IFU_IMEM_DW     32  // Memory data word, two queue halfwords

// --------------------
// Buffering
// --------------------

// Must be a power of two, counted in halfwords
`define IFU_Q_HALVES    4

// All-ones means the outstanding counter is full
`define IFU_TXN_CNT_W   3

`endif

//--- hdl/ifu_pkg.sv
// Instruction fetch unit shared types
// Memory response code, fetch state, queue write kind

package ifu_pkg;

    // --------------------
    // Memory side
    // --------------------

    typedef enum logic [1:0] {
        resp_idle = 2'b00,  // No response this cycle
        resp_ok   = 2'b01,  // Data word valid
        resp_err  = 2'b10   // Access error
    } mem_resp_e;

    // --------------------
    // Internal
    // --------------------

    typedef enum logic {
        st_idle,
        st_fetch
    } fetch_state_e;

    typedef enum logic [1:0] {
        wr_none,            // Nothing written
        wr_full,            // Both halves of the word
        wr_hi               // Upper half only
    } q_write_e;

endpackage

//--- hdl/ifu_fetch_ctrl.sv
// Fetch controller: state machine, request address,
// outstanding and discard counters, request decision

`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_fetch_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 new_pc_req,
    input  logic [`IFU_XLEN-1:0]                 new_pc,
    input  logic                                 stop_fetch,
    input  logic                                 imem_req_ack,
    input  ifu_pkg::mem_resp_e                   imem_resp,
    input  logic [$clog2(`IFU_Q_HALVES/2+1)-1:0] free_words,
    output logic                                 imem_req,
    output logic [`IFU_XLEN-1:0]                 imem_addr,
    output logic                                 keep_ok,
    output logic                                 keep_err,
    output logic                                 flush,
    output logic                                 ifu_busy
);

    import ifu_pkg::*;

    localparam int CNT_W = `IFU_TXN_CNT_W;

    fetch_state_e         state;
    logic [`IFU_XLEN-1:2] next_addr;     // Next sequential word
    logic [`IFU_XLEN-1:2] addr_base;
    logic [CNT_W-1:0]     pending;       // Accepted, not yet answered
    logic [CNT_W-1:0]     discard_cnt;   // Answers still to drop
    logic [CNT_W-1:0]     discard_next;
    logic [CNT_W-1:0]     kept_pending;
    logic                 is_ok;
    logic                 is_err;
    logic                 resp_any;
    logic                 discard;
    logic                 cnt_full;
    logic                 req_acc;

    // --------------------
    // Response decode
    // --------------------

    assign is_ok        = (imem_resp == resp_ok);
    assign is_err       = (imem_resp == resp_err);
    assign resp_any     = is_ok | is_err;
    assign discard      = |discard_cnt;
    assign keep_ok      = is_ok & ~discard;
    assign keep_err     = is_err & ~discard;
    assign flush        = new_pc_req | stop_fetch;
    assign ifu_busy     = (state == st_fetch);

    // --------------------
    // Request decision
    // --------------------

    assign cnt_full     = &pending;
    assign kept_pending = pending - discard_cnt;
    assign addr_base    = new_pc_req ? new_pc[`IFU_XLEN-1:2] : next_addr;

    // A redirect goes out at once, plain fetching needs queue room
    assign imem_req  = ~stop_fetch & ~cnt_full &
                       (new_pc_req | ((state == st_fetch) & (CNT_W'(free_words) > kept_pending)));
    assign imem_addr = {addr_base, 2'b00};
    assign req_acc   = imem_req & imem_req_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_addr <= '0;
        end else if (req_acc) begin
            next_addr <= addr_base + 1'b1;
        end else if (new_pc_req) begin
            next_addr <= new_pc[`IFU_XLEN-1:2];
        end
    end

    // --------------------
    // Counters
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (req_acc & ~resp_any) begin
            pending <= pending + 1'b1;
        end else if (resp_any & ~req_acc) begin
            pending <= pending - 1'b1;
        end
    end

    always_comb begin
        discard_next = discard_cnt;
        if (new_pc_req) begin
            discard_next = pending - CNT_W'(resp_any);   // New request is kept
        end else if (stop_fetch | keep_err) begin
            // Everything in flight after this cycle is dropped
            discard_next = pending - CNT_W'(resp_any) + CNT_W'(req_acc);
        end else if (discard & resp_any) begin
            discard_next = discard_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            discard_cnt <= '0;
        end else begin
            discard_cnt <= discard_next;
        end
    end

    // --------------------
    // FSM
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (new_pc_req & ~stop_fetch) begin
                        state <= st_fetch;
                    end
                end
                default: begin
                    if (stop_fetch | (keep_err & ~new_pc_req)) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- hdl/ifu_word_align.sv
// Word aligner: classifies each kept response word into
// instruction parts and picks the queue write kind

`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_word_align (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    new_pc_req,
    input  logic                    new_pc_odd,
    input  logic                    keep_ok,
    input  logic                    keep_err,
    input  logic [`IFU_IMEM_DW-1:0] imem_rdata,
    output ifu_pkg::q_write_e       wr_kind
);

    import ifu_pkg::*;

    localparam int HALF_W = `IFU_IMEM_DW / 2;

    // Named as upper half then lower half
    typedef enum logic [2:0] {
        wk_none,
        wk_rvi_full,
        wk_rvc_rvc,
        wk_rvi_lo_rvc,
        wk_rvc_rvi_hi,
        wk_rvi_lo_rvi_hi,
        wk_rvc_nv,          // Lower half skipped after odd redirect
        wk_rvi_lo_nv
    } word_kind_e;

    word_kind_e kind;
    logic       carry_hi;   // Previous word ended with a 32-bit lower half
    logic       odd_start;  // Pending word follows an odd redirect
    logic       carry_next;
    logic       lo_rvi;
    logic       hi_rvi;

    assign lo_rvi = &imem_rdata[1:0];
    assign hi_rvi = &imem_rdata[HALF_W +: 2];

    // --------------------
    // Classification
    // --------------------

    always_comb begin
        kind = wk_none;
        if (keep_ok) begin
            if (odd_start) begin
                kind = hi_rvi ? wk_rvi_lo_nv : wk_rvc_nv;
            end else if (carry_hi) begin
                kind = hi_rvi ? wk_rvi_lo_rvi_hi : wk_rvc_rvi_hi;
            end else if (lo_rvi) begin
                kind = wk_rvi_full;
            end else begin
                kind = hi_rvi ? wk_rvi_lo_rvc : wk_rvc_rvc;
            end
        end
    end

    assign carry_next = (kind == wk_rvi_lo_nv) | (kind == wk_rvi_lo_rvi_hi) |
                        (kind == wk_rvi_lo_rvc);

    always_comb begin
        wr_kind = wr_none;
        if (keep_err) begin
            wr_kind = wr_full;              // Error word always fully stored
        end else if (keep_ok) begin
            case (kind)
                wk_rvc_nv, wk_rvi_lo_nv: wr_kind = wr_hi;
                default:                 wr_kind = wr_full;
            endcase
        end
    end

    // --------------------
    // Carry state
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry_hi  <= 1'b0;
            odd_start <= 1'b0;
        end else if (new_pc_req) begin
            carry_hi  <= 1'b0;
            odd_start <= new_pc_odd;
        end else if (keep_ok | keep_err) begin
            carry_hi  <= carry_next;
            odd_start <= 1'b0;
        end
    end

endmodule

//--- hdl/ifu_halfword_queue.sv
// Halfword queue with error flags and read/write pointers
// Assembles 16-bit and 32-bit instructions for the decode stage

`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_halfword_queue (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush,
    input  ifu_pkg::q_write_e                    wr_kind,
    input  logic                                 keep_err,
    input  logic [`IFU_IMEM_DW-1:0]              imem_rdata,
    input  logic                                 instr_ready,
    output logic [$clog2(`IFU_Q_HALVES/2+1)-1:0] free_words,
    output logic [`IFU_IMEM_DW-1:0]              instr,
    output logic                                 instr_err,
    output logic                                 instr_valid
);

    import ifu_pkg::*;

    localparam int HALF_W = `IFU_IMEM_DW / 2;
    localparam int DEPTH  = `IFU_Q_HALVES;
    localparam int ADR_W  = $clog2(DEPTH);
    localparam int PTR_W  = ADR_W + 1;
    localparam int OCC_W  = $clog2(DEPTH + 1);
    localparam int FREE_W = $clog2(DEPTH / 2 + 1);

    logic [HALF_W-1:0] q_data [DEPTH];
    logic              q_err  [DEPTH];
    logic [PTR_W-1:0]  rptr;
    logic [PTR_W-1:0]  wptr;
    logic [PTR_W-1:0]  rptr_next;
    logic [PTR_W-1:0]  wptr_p1;
    logic [OCC_W-1:0]  occ;         // Halfwords held
    logic [OCC_W-1:0]  free_h;      // Free halfwords after this read
    logic              q_empty;
    logic              occ_one;
    logic [HALF_W-1:0] head;
    logic [HALF_W-1:0] head_next;
    logic              head_err;
    logic              head_rvi;
    logic              rd_en;
    logic              rd_two;

    // --------------------
    // Head decode
    // --------------------

    assign occ       = OCC_W'(wptr - rptr);
    assign q_empty   = (rptr == wptr);
    assign occ_one   = (occ == OCC_W'(1));
    assign wptr_p1   = wptr + 1'b1;

    assign head      = q_data[rptr[ADR_W-1:0]];
    assign head_next = q_data[ADR_W'(rptr + 1'b1)];
    assign head_err  = q_err[rptr[ADR_W-1:0]];
    assign head_rvi  = &head[1:0];  // Low bits both one means 32 bits

    // A lone 32-bit lower half waits for its upper half unless it faulted
    assign instr_valid = ~q_empty & (~occ_one | ~head_rvi | head_err);
    assign instr_err   = ~q_empty & head_err;
    assign instr       = head_rvi ? {head_next, head} : `IFU_IMEM_DW'(head);

    // --------------------
    // Pointers
    // --------------------

    assign rd_en  = instr_valid & instr_ready;
    assign rd_two = (head_rvi | head_err) & ~occ_one;   // Faulted word dropped whole

    always_comb begin
        rptr_next = rptr;
        if (rd_en) begin
            rptr_next = rptr + (rd_two ? PTR_W'(2) : PTR_W'(1));
        end
    end

    assign free_h     = OCC_W'(DEPTH) - OCC_W'(wptr - rptr_next);
    assign free_words = FREE_W'(free_h >> 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rptr <= '0;
            wptr <= '0;
        end else if (flush) begin
            rptr <= '0;
            wptr <= '0;
        end else begin
            rptr <= rptr_next;
            case (wr_kind)
                wr_full: wptr <= wptr + PTR_W'(2);
                wr_hi:   wptr <= wptr_p1;
                default: ;
            endcase
        end
    end

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge clk) begin
        if (!flush) begin
            case (wr_kind)
                wr_hi: begin
                    q_data[wptr[ADR_W-1:0]] <= imem_rdata[`IFU_IMEM_DW-1:HALF_W];
                    q_err[wptr[ADR_W-1:0]]  <= keep_err;
                end
                wr_full: begin
                    q_data[wptr[ADR_W-1:0]]    <= imem_rdata[HALF_W-1:0];
                    q_err[wptr[ADR_W-1:0]]     <= keep_err;
                    q_data[wptr_p1[ADR_W-1:0]] <= imem_rdata[`IFU_IMEM_DW-1:HALF_W];
                    q_err[wptr_p1[ADR_W-1:0]]  <= keep_err;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/ifu_top.sv
// Instruction fetch unit top level
// Fetch controller, word aligner and halfword queue

`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // Instruction memory
    output logic                    imem_req,
    input  logic                    imem_req_ack,
    output logic [`IFU_XLEN-1:0]    imem_addr,
    input  logic [`IFU_IMEM_DW-1:0] imem_rdata,
    input  ifu_pkg::mem_resp_e      imem_resp,
    // Core control
    input  logic                    new_pc_req,
    input  logic [`IFU_XLEN-1:0]    new_pc,
    input  logic                    stop_fetch,
    output logic                    ifu_busy,
    // Decode stage
    output logic [`IFU_IMEM_DW-1:0] instr,
    output logic                    instr_err,
    output logic                    instr_valid,
    input  logic                    instr_ready
);

    import ifu_pkg::*;

    localparam int FREE_W = $clog2(`IFU_Q_HALVES / 2 + 1);

    logic              keep_ok;
    logic              keep_err;
    logic              flush;
    q_write_e          wr_kind;
    logic [FREE_W-1:0] free_words;

    ifu_fetch_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .imem_req_ack (imem_req_ack),
        .imem_resp    (imem_resp),
        .free_words   (free_words),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .keep_ok      (keep_ok),
        .keep_err     (keep_err),
        .flush        (flush),
        .ifu_busy     (ifu_busy)
    );

    ifu_word_align align_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_pc_req (new_pc_req),
        .new_pc_odd (new_pc[1]),    // Halfword-aligned redirect
        .keep_ok    (keep_ok),
        .keep_err   (keep_err),
        .imem_rdata (imem_rdata),
        .wr_kind    (wr_kind)
    );

    ifu_halfword_queue queue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .wr_kind     (wr_kind),
        .keep_err    (keep_err),
        .imem_rdata  (imem_rdata),
        .instr_ready (instr_ready),
        .free_words  (free_words),
        .instr       (instr),
        .instr_err   (instr_err),
        .instr_valid (instr_valid)
    );

endmodule

//--- bench/ifu_clk_gen.sv
// Testbench clock source, 20 ns period

`timescale 1ns/1ps

module ifu_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

//--- bench/ifu_asserts.sv
// Protocol assertions for the instruction fetch unit
// Bound into ifu_top

`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    imem_req,
    input logic [`IFU_XLEN-1:0]    imem_addr,
    input logic                    new_pc_req,
    input logic [`IFU_XLEN-1:0]    new_pc,
    input logic                    stop_fetch,
    input logic                    ifu_busy,
    input logic [`IFU_IMEM_DW-1:0] instr,
    input logic                    instr_valid,
    input logic                    instr_ready
);

    // --------------------
    // Memory side
    // --------------------

    // A redirect request goes out for the word holding new_pc
    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req |-> ((imem_addr[1:0] == 2'b00) &&
                      (!new_pc_req || (imem_addr[`IFU_XLEN-1:2] == new_pc[`IFU_XLEN-1:2]))))
        else $error("imem_addr not word-aligned or not at new_pc on request");

    stop_idles: assert property (@(posedge clk) disable iff (!rst_n)
        stop_fetch |=> !ifu_busy)
        else $error("ifu_busy still high after stop_fetch");

    // --------------------
    // Decode side
    // --------------------

    // Held instruction must not change while stalled
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && !instr_ready && !new_pc_req && !stop_fetch)
        |=> (instr_valid && $stable(instr)))
        else $error("instr_valid or instr changed under back-pressure");

endmodule

bind ifu_top ifu_asserts asserts_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .new_pc_req  (new_pc_req),
    .new_pc      (new_pc),
    .stop_fetch  (stop_fetch),
    .ifu_busy    (ifu_busy),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready)
);

//--- bench/ifu_tb.sv
// Instruction fetch unit testbench
// Memory model, directed tests, compare tasks and timeout

`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_tb;

    import ifu_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int MEM_WORDS      = 256;

    logic                    clk;
    logic                    rst_n;
    logic                    imem_req;
    logic                    imem_req_ack;
    logic [`IFU_XLEN-1:0]    imem_addr;
    logic [`IFU_IMEM_DW-1:0] imem_rdata;
    mem_resp_e               imem_resp;
    logic                    new_pc_req;
    logic [`IFU_XLEN-1:0]    new_pc;
    logic                    stop_fetch;
    logic                    ifu_busy;
    logic [`IFU_IMEM_DW-1:0] instr;
    logic                    instr_err;
    logic                    instr_valid;
    logic                    instr_ready;

    logic [31:0]          mem      [MEM_WORDS];
    bit                   err_flag [MEM_WORDS];
    logic [`IFU_XLEN-1:0] pend_addr[$];
    int                   pend_due [$];
    logic [`IFU_XLEN-1:0] got_instr[$];
    bit                   got_err  [$];
    logic [`IFU_XLEN-1:0] exp_q    [$];
    int                   cyc;
    bit                   rand_ready;

    ifu_clk_gen clk_gen_i (.clk(clk));

    ifu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_req_ack (imem_req_ack),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .ifu_busy     (ifu_busy),
        .instr        (instr),
        .instr_err    (instr_err),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready)
    );

    // --------------------
    // Failure reporting
    // --------------------

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_instr(input logic [`IFU_XLEN-1:0] got, input logic [`IFU_XLEN-1:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0t: %s instr %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_err(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0t: %s instr_err %0b expected %0b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_busy(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0t: %s ifu_busy %0b expected %0b",
                                $time, what, got, exp));
        end
    endtask

    // --------------------
    // Memory model
    // --------------------

    // Accept, count cycles and watch the time limit
    always @(posedge clk) begin
        if (rst_n && imem_req && imem_req_ack) begin
            pend_addr.push_back(imem_addr);
            pend_due.push_back(cyc + 2);
        end
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            fail_stop("Timeout: the tests did not finish within the cycle limit");
        end
    end

    always @(negedge clk) begin
        imem_req_ack = ($urandom % 4) != 0;
        instr_ready  = rand_ready ? (($urandom % 3) != 0) : 1'b1;
        if (pend_due.size() > 0 && pend_due[0] == cyc) begin
            imem_rdata = mem[pend_addr[0][9:2]];
            imem_resp  = err_flag[pend_addr[0][9:2]] ? resp_err : resp_ok;
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end else begin
            imem_rdata = '0;
            imem_resp  = resp_idle;
        end
    end

    // Decode-side transfer monitor
    always @(posedge clk) begin
        if (rst_n && instr_valid && instr_ready) begin
            got_instr.push_back(instr);
            got_err.push_back(instr_err);
        end
    end

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [15:0] halfword(input logic [`IFU_XLEN-1:0] addr);
        logic [31:0] w;
        w = mem[addr[9:2]];
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    // Low bits both one means 32 bits
    task automatic build_expected(input logic [`IFU_XLEN-1:0] pc, input int n);
        logic [`IFU_XLEN-1:0] a;
        logic [15:0]          lo;
        a = pc;
        exp_q.delete();
        for (int i = 0; i < n; i++) begin
            lo = halfword(a);
            if (lo[1:0] == 2'b11) begin
                exp_q.push_back({halfword(a + 2), lo});
                a = a + 4;
            end else begin
                exp_q.push_back({16'h0000, lo});
                a = a + 2;
            end
        end
    endtask

    task automatic redirect(input logic [`IFU_XLEN-1:0] pc);
        @(negedge clk);
        new_pc_req = 1'b1;
        new_pc     = pc;
        @(negedge clk);
        new_pc_req = 1'b0;
        check_busy(ifu_busy, 1'b1, "after redirect");
        got_instr.delete();  // Drop anything from the old stream
        got_err.delete();
    endtask

    task automatic stop_and_check;
        @(negedge clk);
        stop_fetch = 1'b1;
        @(negedge clk);
        stop_fetch = 1'b0;
        check_busy(ifu_busy, 1'b0, "after stop_fetch");
        got_instr.delete();
        got_err.delete();
    endtask

    task automatic wait_transfers(input int n);
        while (got_instr.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic compare_stream(input logic [`IFU_XLEN-1:0] pc, input int n, input string what);
        build_expected(pc, n);
        for (int i = 0; i < n; i++) begin
            check_instr(got_instr[i], exp_q[i], $sformatf("%s #%0d", what, i));
            check_err(got_err[i], 1'b0, $sformatf("%s #%0d", what, i));
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------

    task automatic test_aligned_rvi;
        for (int i = 0; i < 32; i++) begin
            mem[i] = (i * 32'h0101_0405 + 32'h0040_0000) | 32'h3;
        end
        rand_ready = 1'b1;
        redirect(32'h0000_0000);
        wait_transfers(12);
        compare_stream(32'h0000_0000, 12, "aligned rvi");
        rand_ready = 1'b0;
        stop_and_check();
    endtask

    task automatic test_mixed;
        mem[64] = {16'h0513, 16'h4501};   // 32-bit lower half in the upper half
        mem[65] = {16'h8082, 16'h00a5};
        mem[66] = 32'h00c5_0533;
        mem[67] = {16'h4185, 16'h0291};
        redirect(32'h0000_0100);
        wait_transfers(10);
        compare_stream(32'h0000_0100, 10, "mixed");
        check_instr(got_instr[1], 32'h00a5_0513, "crossing instr");
        stop_and_check();
    endtask

    task automatic test_odd_redirect;
        redirect(32'h0000_0202);
        wait_transfers(8);
        compare_stream(32'h0000_0202, 8, "odd redirect");
        stop_and_check();
    endtask

    task automatic test_redirect_in_flight;
        redirect(32'h0000_0300);
        repeat (2) @(negedge clk);
        redirect(32'h0000_0340);
        wait_transfers(10);
        compare_stream(32'h0000_0340, 10, "second redirect");
        stop_and_check();
    endtask

    task automatic test_access_error;
        logic [7:0] k;
        for (int i = 224; i < 232; i++) begin
            k = i[7:0];
            mem[i] = {6'h11, k, 2'b01, 6'h22, k, 2'b10};   // Two 16-bit instrs
        end
        err_flag[227] = 1'b1;
        redirect(32'h0000_0380);
        wait_transfers(7);
        compare_stream(32'h0000_0380, 6, "before error");
        check_err(got_err[6], 1'b1, "faulted word");
        repeat (20) @(negedge clk);
        check_busy(ifu_busy, 1'b0, "after access error");
        if (got_instr.size() != 7) begin
            fail_stop("An instruction was delivered after the access error");
        end
        err_flag[227] = 1'b0;
    endtask

    task automatic test_stop;
        redirect(32'h0000_0000);
        wait_transfers(4);
        stop_and_check();
        repeat (20) begin
            @(negedge clk);
            if (instr_valid) begin
                fail_stop("instr_valid went high after stop_fetch");
            end
        end
        if (got_instr.size() != 0) begin
            fail_stop("An instruction was transferred after stop_fetch");
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        void'($urandom(48));
        rst_n        = 1'b0;
        new_pc_req   = 1'b0;
        new_pc       = '0;
        stop_fetch   = 1'b0;
        imem_req_ack = 1'b0;
        imem_resp    = resp_idle;
        imem_rdata   = '0;
        instr_ready  = 1'b0;
        rand_ready   = 1'b0;
        cyc          = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]      = 32'h1357_9bdf ^ (i * 32'h0001_0203) ^ (i << 20);
            err_flag[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_busy(ifu_busy, 1'b0, "after reset");
        if (imem_req || instr_valid) begin
            fail_stop("imem_req or instr_valid was high right after reset");
        end

        test_aligned_rvi();
        test_mixed();
        test_odd_redirect();
        test_redirect_in_flight();
        test_access_error();
        test_stop();

        repeat (2) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/ifu_pkg.sv
hdl/ifu_fetch_ctrl.sv
hdl/ifu_word_align.sv
hdl/ifu_halfword_queue.sv
hdl/ifu_top.sv
bench/ifu_clk_gen.sv
bench/ifu_asserts.sv
bench/ifu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := ifu_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)
